/* hw/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// processor side
`define MEM_ADDR_W 18
`define MEM_DATA_W 32
`define MEM_LINE_W 64

// cache geometry, two ways of 64-bit lines
`define CACHE_SETS 64
`define CACHE_INDEX_W 6
`define CACHE_TAG_W 9
`define CACHE_WORD_BIT 2
`define CACHE_INDEX_LSB 3
`define CACHE_TAG_LSB 9

// halfword-addressed sram
`define SRAM_DATA_W 16
`define SRAM_ADDR_W 17
`define SRAM_DEPTH 131072
`define SRAM_READ_BEATS 4
`define SRAM_WRITE_BEATS 2
`define SRAM_BEAT_W 2

`endif

/* hw/cache_pkg.sv */
`include "mem_defs.svh"

package cache_pkg;

    // address fields
    typedef logic [`CACHE_TAG_W-1:0] cache_tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] cache_index_t;

    // one full line, low word in the low half
    typedef logic [`MEM_LINE_W-1:0] cache_line_t;

    // outcome of comparing both ways against the address tag
    typedef enum logic [1:0] {
        miss,
        hit_way0,
        hit_way1
    } way_hit_e;

endpackage

/* hw/sram_pkg.sv */
`include "mem_defs.svh"

package sram_pkg;

    // array side
    typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;
    typedef logic [`SRAM_DATA_W-1:0] sram_half_t;

    // counts beats within one transfer
    typedef logic [`SRAM_BEAT_W-1:0] sram_beat_t;

    // beat sequencer states
    typedef enum logic [1:0] {
        idle,
        read_beat,
        write_beat,
        done
    } sram_state_e;

endpackage

/* hw/sram_array.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module sram_array (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sram_we,
    input  sram_pkg::sram_addr_t    sram_addr,
    input  sram_pkg::sram_half_t    sram_din,
    output sram_pkg::sram_half_t    sram_dout
);
    import sram_pkg::*;

    sram_half_t mem [0:`SRAM_DEPTH-1];

    // array starts out all zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `SRAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
            sram_dout <= '0;
        end else begin
            if (sram_we) begin
                mem[sram_addr] <= sram_din;
            end
            // registered read, old data on a same-cycle write
            sram_dout <= mem[sram_addr];
        end
    end

endmodule

/* hw/sram_controller.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module sram_controller (
    input  logic                        clk,
    input  logic                        rst,

    // cache side
    input  logic                        sram_r_en,
    input  logic                        sram_w_en,
    input  logic [`MEM_ADDR_W-1:0]      sram_address,
    input  logic [`MEM_DATA_W-1:0]      sram_wdata,
    output logic [`MEM_LINE_W-1:0]      sram_rdata,
    output logic                        sram_ready,

    // array side
    input  sram_pkg::sram_half_t        sram_dout,
    output logic                        sram_we,
    output sram_pkg::sram_addr_t        sram_addr,
    output sram_pkg::sram_half_t        sram_din
);
    import sram_pkg::*;

    sram_state_e state_q;
    sram_beat_t  beat_q;
    sram_beat_t  next_beat;
    sram_addr_t  base_q;
    sram_addr_t  line_base;
    sram_addr_t  word_base;
    logic [`MEM_DATA_W-1:0] wdata_q;
    logic [`MEM_LINE_W-1:0] line_q;

    // halfword addresses of the line and of the word
    assign line_base = {sram_address[`MEM_ADDR_W-1:3], 2'b00};
    assign word_base = {sram_address[`MEM_ADDR_W-1:2], 1'b0};
    assign next_beat = sram_beat_t'(beat_q + 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= idle;
            beat_q  <= '0;
        end else begin
            case (state_q)
                idle: begin
                    beat_q <= '0;
                    if (sram_w_en) begin
                        state_q <= write_beat;
                    end else if (sram_r_en) begin
                        state_q <= read_beat;
                    end
                end
                read_beat: begin
                    beat_q <= next_beat;
                    if (beat_q == sram_beat_t'(`SRAM_READ_BEATS - 1)) begin
                        state_q <= done;
                    end
                end
                write_beat: begin
                    beat_q <= next_beat;
                    if (beat_q == sram_beat_t'(`SRAM_WRITE_BEATS - 1)) begin
                        state_q <= done;
                    end
                end
                default: begin
                    state_q <= idle;
                end
            endcase
        end
    end

    // request operands and the assembled line
    always_ff @(posedge clk) begin
        if (state_q == idle) begin
            base_q  <= sram_w_en ? word_base : line_base;
            wdata_q <= sram_wdata;
        end
        // array data trails the address by one cycle
        if (state_q == read_beat) begin
            line_q <= {sram_dout, line_q[`MEM_LINE_W-1:`SRAM_DATA_W]};
        end
    end

    // first read beat goes out while still idle
    always_comb begin
        case (state_q)
            idle:       sram_addr = line_base;
            read_beat:  sram_addr = {base_q[`SRAM_ADDR_W-1:2], next_beat};
            write_beat: sram_addr = {base_q[`SRAM_ADDR_W-1:1], beat_q[0]};
            default:    sram_addr = base_q;
        endcase
    end

    assign sram_we    = (state_q == write_beat);
    assign sram_din   = beat_q[0] ? wdata_q[`MEM_DATA_W-1:`SRAM_DATA_W]
                                  : wdata_q[`SRAM_DATA_W-1:0];
    assign sram_ready = (state_q == done);
    assign sram_rdata = line_q;

endmodule

/* hw/cache_controller.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module cache_controller (
    input  logic                        clk,
    input  logic                        rst,

    // memory stage
    input  logic [`MEM_ADDR_W-1:0]      address,
    input  logic [`MEM_DATA_W-1:0]      wdata,
    input  logic                        mem_r_en,
    input  logic                        mem_w_en,
    output logic [`MEM_DATA_W-1:0]      rdata,
    output logic                        ready,

    // sram controller
    input  cache_pkg::cache_line_t      sram_rdata,
    input  logic                        sram_ready,
    output logic [`MEM_ADDR_W-1:0]      sram_address,
    output logic [`MEM_DATA_W-1:0]      sram_wdata,
    output logic                        sram_r_en,
    output logic                        sram_w_en
);
    import cache_pkg::*;

    cache_tag_t   tag;
    cache_index_t index;
    logic         word_sel;

    // storage, indexed by way then set
    cache_tag_t  tag_q  [0:1][0:`CACHE_SETS-1];
    cache_line_t data_q [0:1][0:`CACHE_SETS-1];
    logic [1:0]  valid_q [0:`CACHE_SETS-1];
    // way used last in each set
    logic [`CACHE_SETS-1:0] lru_q;

    way_hit_e    way_hit;
    logic        read_hit;
    logic        fill_en;
    logic        inval_en;
    logic        victim;
    cache_line_t hit_line;
    cache_line_t out_line;

    assign tag      = address[`MEM_ADDR_W-1:`CACHE_TAG_LSB];
    assign index    = address[`CACHE_TAG_LSB-1:`CACHE_INDEX_LSB];
    assign word_sel = address[`CACHE_WORD_BIT];

    always_comb begin
        if (valid_q[index][0] && (tag_q[0][index] == tag)) begin
            way_hit = hit_way0;
        end else if (valid_q[index][1] && (tag_q[1][index] == tag)) begin
            way_hit = hit_way1;
        end else begin
            way_hit = miss;
        end
    end

    // stores never count as hits on the read path
    assign read_hit = mem_r_en && !mem_w_en && (way_hit != miss);
    assign fill_en  = mem_r_en && !mem_w_en && (way_hit == miss) && sram_ready;
    assign inval_en = mem_w_en && sram_ready;
    assign victim   = ~lru_q[index];

    assign hit_line = (way_hit == hit_way1) ? data_q[1][index] : data_q[0][index];
    assign out_line = read_hit ? hit_line : sram_rdata;
    assign rdata    = word_sel ? out_line[`MEM_LINE_W-1:`MEM_DATA_W]
                               : out_line[`MEM_DATA_W-1:0];

    assign ready = (mem_w_en && sram_ready)
                 || (mem_r_en && (read_hit || sram_ready))
                 || !(mem_r_en || mem_w_en);

    // write through, no allocate
    assign sram_address = address;
    assign sram_wdata   = mem_w_en ? wdata : '0;
    assign sram_w_en    = mem_w_en;
    assign sram_r_en    = mem_r_en && !mem_w_en && (way_hit == miss);

    // valid and lru bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CACHE_SETS; i++) begin
                valid_q[i] <= 2'b00;
            end
            lru_q <= '0;
        end else begin
            if (inval_en) begin
                // a hit way goes stale once the store reaches sram
                if (way_hit == hit_way0) begin
                    valid_q[index][0] <= 1'b0;
                end else if (way_hit == hit_way1) begin
                    valid_q[index][1] <= 1'b0;
                end
            end
            if (read_hit) begin
                lru_q[index] <= (way_hit == hit_way1);
            end else if (fill_en) begin
                valid_q[index][victim] <= 1'b1;
                lru_q[index]           <= victim;
            end
        end
    end

    // line fill into the victim way
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[victim][index]  <= tag;
            data_q[victim][index] <= sram_rdata;
        end
    end

endmodule

/* hw/mem_subsystem.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsystem (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`MEM_ADDR_W-1:0]      address,
    input  logic [`MEM_DATA_W-1:0]      wdata,
    input  logic                        mem_r_en,
    input  logic                        mem_w_en,
    output logic [`MEM_DATA_W-1:0]      rdata,
    output logic                        ready
);

    // cache to sram controller
    logic [`MEM_ADDR_W-1:0]  sram_address;
    logic [`MEM_DATA_W-1:0]  sram_wdata;
    logic [`MEM_LINE_W-1:0]  sram_rdata;
    logic                    sram_r_en;
    logic                    sram_w_en;
    logic                    sram_ready;

    // sram controller to array
    logic                    sram_we;
    logic [`SRAM_ADDR_W-1:0] sram_addr;
    logic [`SRAM_DATA_W-1:0] sram_din;
    logic [`SRAM_DATA_W-1:0] sram_dout;

    cache_controller cache_controller_inst (
        .clk          (clk),
        .rst          (rst),
        .address      (address),
        .wdata        (wdata),
        .mem_r_en     (mem_r_en),
        .mem_w_en     (mem_w_en),
        .rdata        (rdata),
        .ready        (ready),
        .sram_rdata   (sram_rdata),
        .sram_ready   (sram_ready),
        .sram_address (sram_address),
        .sram_wdata   (sram_wdata),
        .sram_r_en    (sram_r_en),
        .sram_w_en    (sram_w_en)
    );

    sram_controller sram_controller_inst (
        .clk          (clk),
        .rst          (rst),
        .sram_r_en    (sram_r_en),
        .sram_w_en    (sram_w_en),
        .sram_address (sram_address),
        .sram_wdata   (sram_wdata),
        .sram_rdata   (sram_rdata),
        .sram_ready   (sram_ready),
        .sram_dout    (sram_dout),
        .sram_we      (sram_we),
        .sram_addr    (sram_addr),
        .sram_din     (sram_din)
    );

    sram_array sram_array_inst (
        .clk       (clk),
        .rst       (rst),
        .sram_we   (sram_we),
        .sram_addr (sram_addr),
        .sram_din  (sram_din),
        .sram_dout (sram_dout)
    );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

endmodule

/* test/mem_subsystem_sva.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsystem_sva (
    input logic                   clk,
    input logic                   rst,
    input logic [`MEM_ADDR_W-1:0] address,
    input logic                   mem_r_en,
    input logic                   mem_w_en,
    input logic                   ready,
    input logic                   sram_r_en,
    input logic                   sram_ready,
    input cache_pkg::way_hit_e    way_hit
);
    import cache_pkg::*;

    // the next read of a line just filled hits without a fetch
    no_fetch_on_hit: assert property (
        @(posedge clk) disable iff (rst)
        (mem_r_en && !mem_w_en && $past(sram_r_en && sram_ready)
            && $stable(address[`MEM_ADDR_W-1:`CACHE_INDEX_LSB]))
            |-> (ready && !sram_r_en)
    ) else $error("sram_r_en high on a read of a line just filled");

    // done lasts a single cycle
    sram_ready_pulse: assert property (
        @(posedge clk) disable iff (rst)
        sram_ready |=> !sram_ready
    ) else $error("sram_ready held for more than one cycle");

    // a store leaves no valid copy of its line behind
    store_drops_line: assert property (
        @(posedge clk) disable iff (rst)
        (mem_r_en && !mem_w_en && $past(mem_w_en && sram_ready)
            && $stable(address[`MEM_ADDR_W-1:`CACHE_INDEX_LSB]))
            |-> (way_hit == miss)
    ) else $error("line still hits right after a store to it");

endmodule

/* test/mem_subsystem_tb.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsystem_tb;

    localparam int RESET_CYCLES     = 16;
    localparam int READ_MISS_CYCLES = 5;
    localparam int WRITE_CYCLES     = 3;

    logic                   clk;
    logic                   rst;
    logic [`MEM_ADDR_W-1:0] address;
    logic [`MEM_DATA_W-1:0] wdata;
    logic                   mem_r_en;
    logic                   mem_w_en;
    logic [`MEM_DATA_W-1:0] rdata;
    logic                   ready;

    // one entry per request in the data file
    logic                   rec_write [$];
    logic [`MEM_ADDR_W-1:0] rec_addr  [$];
    logic [`MEM_DATA_W-1:0] rec_wdata [$];
    logic [`MEM_DATA_W-1:0] rec_exp   [$];
    logic                   rec_hit   [$];

    int cycle_count = 0;
    int cycle_limit;

    tb_clock_gen clock_gen_inst (
        .clk (clk)
    );

    mem_subsystem mem_subsystem_inst (
        .clk      (clk),
        .rst      (rst),
        .address  (address),
        .wdata    (wdata),
        .mem_r_en (mem_r_en),
        .mem_w_en (mem_w_en),
        .rdata    (rdata),
        .ready    (ready)
    );

    bind cache_controller mem_subsystem_sva mem_subsystem_sva_inst (
        .clk        (clk),
        .rst        (rst),
        .address    (address),
        .mem_r_en   (mem_r_en),
        .mem_w_en   (mem_w_en),
        .ready      (ready),
        .sram_r_en  (sram_r_en),
        .sram_ready (sram_ready),
        .way_hit    (way_hit)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            abort_run("mismatch against the expected value");
        end
    endtask

    task automatic load_records();
        int               fd;
        int               fields;
        logic [8*128-1:0] text_line;
        logic [31:0]      f_op;
        logic [31:0]      f_addr;
        logic [31:0]      f_wdata;
        logic [31:0]      f_exp;
        logic [31:0]      f_hit;
        fd = $fopen("test/mem_subsystem_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open test/mem_subsystem_testdata.txt");
        end
        // comment lines do not scan as five hex fields
        while ($fgets(text_line, fd) != 0) begin
            fields = $sscanf(text_line, "%h %h %h %h %h", f_op, f_addr, f_wdata, f_exp, f_hit);
            if (fields == 5) begin
                rec_write.push_back(f_op[0]);
                rec_addr.push_back(f_addr[`MEM_ADDR_W-1:0]);
                rec_wdata.push_back(f_wdata);
                rec_exp.push_back(f_exp);
                rec_hit.push_back(f_hit[0]);
            end
        end
        $fclose(fd);
    endtask

    // issue one request and hold it until ready before returning on the accepting edge
    task automatic run_request(input int idx);
        int          latency;
        int          expected_latency;
        logic        is_write;
        logic [31:0] read_value;
        is_write = rec_write[idx];
        if (is_write) begin
            expected_latency = WRITE_CYCLES;
        end else if (rec_hit[idx]) begin
            expected_latency = 0;
        end else begin
            expected_latency = READ_MISS_CYCLES;
        end
        address  <= rec_addr[idx];
        wdata    <= rec_wdata[idx];
        mem_r_en <= !is_write;
        mem_w_en <= is_write;
        latency = 0;
        @(negedge clk);
        while (!ready) begin
            latency++;
            @(negedge clk);
        end
        read_value = rdata;
        check_value($sformatf("ready latency (record %0d)", idx), latency, expected_latency);
        if (!is_write) begin
            check_value($sformatf("rdata (record %0d)", idx), read_value, rec_exp[idx]);
        end
        @(posedge clk);
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("timeout: the request sequence did not finish within the cycle limit");
        end
    end

    initial begin
        rst         = 1'b1;
        address     = '0;
        wdata       = '0;
        mem_r_en    = 1'b0;
        mem_w_en    = 1'b0;
        load_records();
        if (rec_write.size() == 0) begin
            abort_run("no requests found in the test data file");
        end
        cycle_limit = 10 * rec_write.size() * 8 + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // each request follows on the edge that saw the previous ready
        foreach (rec_write[i]) begin
            run_request(i);
        end
        mem_r_en <= 1'b0;
        mem_w_en <= 1'b0;
        @(posedge clk);
        $display("%0d requests checked", rec_write.size());
        $display("All tests passed");
        $finish;
    end

endmodule

/* test/mem_subsystem_testdata.txt */
// columns: op address wdata expected_rdata hit, all hex
// op 0 is a read and 1 a write; hit 1 means the read answers with zero latency
1 00028 11112222 00000000 0
1 0002C 33334444 00000000 0
0 00028 00000000 11112222 0
0 0002C 00000000 33334444 1
0 00030 00000000 00000000 0
0 00034 00000000 00000000 1
// three tags on set 5
1 00228 AAAA5555 00000000 0
0 00228 00000000 AAAA5555 0
0 0002C 00000000 33334444 1
0 0042C 00000000 00000000 0
0 00028 00000000 11112222 1
0 0022C 00000000 00000000 0
0 00228 00000000 AAAA5555 1
// stores that hit drop the line
1 00228 0BADF00D 00000000 0
0 0002C 00000000 33334444 1
0 00228 00000000 0BADF00D 0
0 0022C 00000000 00000000 1
1 0002C 12345678 00000000 0
0 00028 00000000 11112222 0
0 0002C 00000000 12345678 1
0 00228 00000000 0BADF00D 1
// top of the address range, set 63
1 3FFF8 CAFEBABE 00000000 0
1 3FFFC DEADBEEF 00000000 0
0 3FFFC 00000000 DEADBEEF 0
0 3FFF8 00000000 CAFEBABE 1
0 1FFF8 00000000 00000000 0
0 3FFF8 00000000 CAFEBABE 1
0 00030 00000000 00000000 1

/* list.f */
+incdir+hw
hw/cache_pkg.sv
hw/sram_pkg.sv
hw/sram_array.sv
hw/sram_controller.sv
hw/cache_controller.sv
hw/mem_subsystem.sv
test/tb_clock_gen.sv
test/mem_subsystem_sva.sv
test/mem_subsystem_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mem_subsystem_tb
FILELIST = list.f

BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
